/* common/fetch_pkg.sv */
package fetch_pkg;

    // Datapath width
    localparam int xlen = 32;

    // Byte address as seen by the cache and the instruction memory
    localparam int addr_width = 16;

    // Byte offset inside one 32-bit word
    localparam int offset_bits = 2;

    // Instruction memory covers the whole 16-bit byte space
    localparam int imem_words = 16384;
    localparam int imem_index_bits = $clog2(imem_words);

    // Cycles from a held address to valid read data
    localparam int imem_latency = 2;

    typedef logic [xlen-1:0] instr_t;

    // Only the low addr_width bits of the PC reach the cache
    typedef logic [xlen-1:0] pc_t;

endpackage

/* icache/icache.sv */
`timescale 1ns/100ps
`default_nettype none

module icache #(
    parameter int sets = 32
) (
    input  wire                clk_in,
    input  wire                rst_in,
    input  wire                annul,
    input  fetch_pkg::pc_t     pc,
    input  fetch_pkg::instr_t  imem_data,
    output fetch_pkg::instr_t  instruction,
    output logic               cache_miss,
    output fetch_pkg::pc_t     imem_addr
);

    // Byte address layout from the top down
    //   tag | set index | byte offset
    localparam int index_bits = $clog2(sets);
    localparam int tag_lsb    = fetch_pkg::offset_bits + index_bits;
    localparam int tag_bits   = fetch_pkg::addr_width - tag_lsb;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_wait2
    } state_t;

    state_t state;

    // Line storage, one word per line
    fetch_pkg::instr_t   data_mem [sets][2];
    logic [tag_bits-1:0] tag_mem  [sets][2];

    // Control state
    logic [1:0]          valid    [sets];
    logic [sets-1:0]     lru;

    logic [index_bits-1:0] set_idx;
    logic [tag_bits-1:0]   tag;
    logic [1:0]            way_hit;
    logic                  cache_hit;
    logic                  fill;
    logic                  fill_way;
    fetch_pkg::instr_t     hit_data;

    assign set_idx = pc[fetch_pkg::offset_bits +: index_bits];
    assign tag     = pc[tag_lsb +: tag_bits];

    // Tag compare on both ways of the set
    assign way_hit[0] = valid[set_idx][0] && (tag_mem[set_idx][0] == tag);
    assign way_hit[1] = valid[set_idx][1] && (tag_mem[set_idx][1] == tag);
    assign cache_hit  = |way_hit;

    // Data comes from whichever way matched
    assign hit_data = way_hit[1] ? data_mem[set_idx][1] : data_mem[set_idx][0];

    // Memory word is ready in the third cycle of a miss
    assign fill     = (state == st_wait2);
    assign fill_way = lru[set_idx];

    assign cache_miss  = !(cache_hit || fill);
    assign instruction = fill ? imem_data : hit_data;

    // PC stays put while a miss is pending
    assign imem_addr = pc;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= st_idle;
            lru   <= '0;
            for (int i = 0; i < sets; i++) begin
                valid[i] <= '0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (!cache_hit && !annul) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    state <= annul ? st_idle : st_wait2;
                end
                st_wait2: begin
                    // Fill finishes even under annul
                    valid[set_idx][fill_way] <= 1'b1;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase

            // Point LRU at the way that did not hit
            if (cache_hit) begin
                lru[set_idx] <= way_hit[0];
            end
        end
    end

    // Line write into the LRU way
    always_ff @(posedge clk_in) begin
        if (fill) begin
            data_mem[set_idx][fill_way] <= imem_data;
            tag_mem[set_idx][fill_way]  <= tag;
        end
    end

    pc_aligned: assert property (
        @(posedge clk_in) disable iff (rst_in)
        pc[fetch_pkg::offset_bits-1:0] == '0
    ) else $error("icache: unaligned pc %h", pc);

    single_way_hit: assert property (
        @(posedge clk_in) disable iff (rst_in)
        !(way_hit[0] && way_hit[1])
    ) else $error("icache: both ways hit in set %0d", set_idx);

    // Fill writes the tag of the address that was read
    pc_held_on_miss: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (state == st_wait || state == st_wait2) |-> $stable(pc)
    ) else $error("icache: pc moved while a miss was pending");

endmodule

`default_nettype wire

/* hw/imem.sv */
`timescale 1ns/100ps
`default_nettype none

module imem (
    input  wire                                        clk_in,
    input  wire                                        rst_in,
    input  fetch_pkg::pc_t                             addr,
    input  wire                                        we,
    input  wire [fetch_pkg::imem_index_bits-1:0]       waddr,
    input  fetch_pkg::instr_t                          wdata,
    output fetch_pkg::instr_t                          rdata
);

    fetch_pkg::instr_t mem [fetch_pkg::imem_words];

    // Read pipeline whose last stage drives rdata
    fetch_pkg::instr_t rd_pipe [fetch_pkg::imem_latency];

    logic [fetch_pkg::imem_index_bits-1:0] rd_idx;

    // Byte address to word index
    assign rd_idx = addr[fetch_pkg::offset_bits +: fetch_pkg::imem_index_bits];

    // Program load port
    always_ff @(posedge clk_in) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < fetch_pkg::imem_latency; i++) begin
                rd_pipe[i] <= '0;
            end
        end else begin
            rd_pipe[0] <= mem[rd_idx];
            for (int i = 1; i < fetch_pkg::imem_latency; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    assign rdata = rd_pipe[fetch_pkg::imem_latency-1];

    raddr_in_range: assert property (
        @(posedge clk_in) disable iff (rst_in)
        addr[fetch_pkg::xlen-1:fetch_pkg::addr_width] == '0
    ) else $error("imem: read address %h outside the memory", addr);

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
    parameter fetch_pkg::pc_t reset_pc = '0
) (
    input  wire                clk_in,
    input  wire                rst_in,
    input  wire                run,
    input  wire                redirect_valid,
    input  fetch_pkg::pc_t     redirect_pc,
    input  fetch_pkg::instr_t  instruction,
    input  wire                cache_miss,
    output fetch_pkg::pc_t     pc,
    output logic               annul,
    output logic               fetch_valid,
    output fetch_pkg::pc_t     fetch_pc,
    output fetch_pkg::instr_t  fetch_instr
);

    // One word per step
    localparam fetch_pkg::pc_t pc_step = fetch_pkg::pc_t'(1) << fetch_pkg::offset_bits;

    logic take_redirect;

    // Redirect only counts while running
    assign take_redirect = run && redirect_valid;

    // Tells the cache to drop a miss that is still waiting
    assign annul = take_redirect;

    // Report when the cache has the word this cycle
    assign fetch_valid = run && !redirect_valid && !cache_miss;
    assign fetch_pc    = pc;
    assign fetch_instr = instruction;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc <= reset_pc;
        end else if (take_redirect) begin
            pc <= redirect_pc;
        end else if (fetch_valid) begin
            pc <= pc + pc_step;
        end
    end

    // Also catches a misaligned redirect target one cycle later
    pc_word_aligned: assert property (
        @(posedge clk_in) disable iff (rst_in)
        pc[fetch_pkg::offset_bits-1:0] == '0
    ) else $error("fetch_unit: pc %h not word aligned", pc);

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int             sets     = 32,
    parameter fetch_pkg::pc_t reset_pc = '0
) (
    input  wire                                   clk_in,
    input  wire                                   rst_in,
    input  wire                                   run,
    input  wire                                   redirect_valid,
    input  fetch_pkg::pc_t                        redirect_pc,
    input  wire                                   prog_we,
    input  wire [fetch_pkg::imem_index_bits-1:0]  prog_addr,
    input  fetch_pkg::instr_t                     prog_data,
    output logic                                  fetch_valid,
    output fetch_pkg::pc_t                        fetch_pc,
    output fetch_pkg::instr_t                     fetch_instr
);

    fetch_pkg::pc_t    pc;
    logic              annul;
    fetch_pkg::instr_t instruction;
    logic              cache_miss;
    fetch_pkg::pc_t    imem_addr;
    fetch_pkg::instr_t imem_data;

    fetch_unit #(
        .reset_pc       (reset_pc)
    ) u_fetch_unit (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instruction    (instruction),
        .cache_miss     (cache_miss),
        .pc             (pc),
        .annul          (annul),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr)
    );

    icache #(
        .sets           (sets)
    ) u_icache (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .annul          (annul),
        .pc             (pc),
        .imem_data      (imem_data),
        .instruction    (instruction),
        .cache_miss     (cache_miss),
        .imem_addr      (imem_addr)
    );

    imem u_imem (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .addr           (imem_addr),
        .we             (prog_we),
        .waddr          (prog_addr),
        .wdata          (prog_data),
        .rdata          (imem_data)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int period       = 8,
    parameter int reset_cycles = 2
) (
    input  logic reset_req,
    output logic clk_in,
    output logic rst_in
);

    initial begin
        clk_in = 1'b0;
        forever #(period / 2) clk_in = ~clk_in;
    end

    // Power-on reset, then again on each request
    initial begin
        rst_in = 1'b1;
        repeat (reset_cycles) @(posedge clk_in);
        #1 rst_in = 1'b0;
        forever begin
            @(posedge clk_in);
            if (reset_req) begin
                #1 rst_in = 1'b1;
                repeat (reset_cycles) @(posedge clk_in);
                #1 rst_in = 1'b0;
            end
        end
    end

endmodule

/* testbench/fetch_tb.sv */
`timescale 1ns/100ps

module fetch_tb;

    localparam int sets     = 4;
    localparam int max_recs = 512;

    logic        clk_in;
    logic        rst_in;
    logic        reset_req;
    logic        run;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        prog_we;
    logic [13:0] prog_addr;
    logic [31:0] prog_data;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_instr;

    // Four words per record line for op, a, b and c
    logic [31:0] recs [0:max_recs-1];

    // Reference memory and cache model with tags, valid and LRU bits, miss FSM and pc
    logic [31:0] model_mem [16384];
    logic        m_valid [sets][2];
    logic [11:0] m_tag   [sets][2];
    logic        m_lru   [sets];
    int          m_state;
    logic [31:0] m_pc;

    int          rp_k [$];
    logic [31:0] rp_pc [$];
    int          rp_delay [$];

    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    int          test_fetches;
    int          test_misses;
    logic        rst_seen;
    logic        fetch_seen;
    logic        pending_reset;
    longint      budget_cycles;

    tb_clock u_tb_clock (
        .reset_req (reset_req),
        .clk_in    (clk_in),
        .rst_in    (rst_in)
    );

    fetch_top #(
        .sets           (sets),
        .reset_pc       (32'h0)
    ) u_fetch_top (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .prog_we        (prog_we),
        .prog_addr      (prog_addr),
        .prog_data      (prog_data),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic reset_model();
        for (int s = 0; s < sets; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        m_state = 0;
        m_pc    = 32'h0;
    endtask

    // Drive after the edge, check mid-cycle and advance the model at the edge
    task automatic run_cycle(input logic run_v, input logic rv_v, input logic [31:0] rpc_v,
                             input logic we_v, input logic [13:0] wa_v,
                             input logic [31:0] wd_v, input logic req_v);
        logic [1:0]  idx;
        logic [11:0] tg;
        logic        h0;
        logic        h1;
        logic        hit;
        logic        fill;
        logic        annul_v;
        logic        exp_valid;
        #1;
        run            = run_v;
        redirect_valid = rv_v;
        redirect_pc    = rpc_v;
        prog_we        = we_v;
        prog_addr      = wa_v;
        prog_data      = wd_v;
        reset_req      = req_v;
        #5;
        rst_seen   = rst_in;
        idx        = m_pc[3:2];
        tg         = m_pc[15:4];
        h0         = m_valid[idx][0] && (m_tag[idx][0] == tg);
        h1         = m_valid[idx][1] && (m_tag[idx][1] == tg);
        hit        = h0 || h1;
        fill       = (m_state == 2);
        annul_v    = run_v && rv_v;
        exp_valid  = run_v && !rv_v && (hit || fill);
        fetch_seen = 1'b0;
        if (!rst_seen) begin
            check_value("fetch_valid", 32'(fetch_valid), 32'(exp_valid));
            if (exp_valid) begin
                check_value("fetch_pc", fetch_pc, m_pc);
                check_value("fetch_instr", fetch_instr, model_mem[m_pc[15:2]]);
                fetch_seen = 1'b1;
                test_fetches++;
                if (fill) begin
                    test_misses++;
                end
            end
        end
        @(posedge clk_in);
        if (we_v) begin
            model_mem[wa_v] = wd_v;
        end
        if (rst_seen) begin
            reset_model();
        end else begin
            case (m_state)
                0: if (!hit && !annul_v) m_state = 1;
                1: m_state = annul_v ? 0 : 2;
                default: begin
                    m_valid[idx][m_lru[idx]] = 1'b1;
                    m_tag[idx][m_lru[idx]]   = tg;
                    m_state = 0;
                end
            endcase
            if (hit) begin
                m_lru[idx] = h0;
            end
            if (annul_v) begin
                m_pc = rpc_v;
            end else if (exp_valid) begin
                m_pc = m_pc + 32'd4;
            end
        end
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, 1'b0, 32'h0, 1'b0, 14'h0, 32'h0, 1'b0);
    endtask

    task automatic wait_reset_done();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 10; i++) begin
            idle_cycle();
            if (rst_seen) begin
                seen = 1'b1;
            end else if (seen) begin
                break;
            end
        end
    endtask

    task automatic apply_reset();
        run_cycle(1'b0, 1'b0, 32'h0, 1'b0, 14'h0, 32'h0, 1'b1);
        wait_reset_done();
    endtask

    task automatic do_fetches(input int n);
        int          done;
        int          guard;
        int          cd;
        logic        armed;
        logic        rv_v;
        logic [31:0] rpc_v;
        done  = 0;
        guard = 0;
        cd    = 0;
        armed = 1'b0;
        while (done < n) begin
            if (guard > n * 3 + 20) begin
                $display("Test %0d: fetch run stalled after %0d of %0d fetches",
                         tests, done, n);
                errors++;
                test_errors++;
                break;
            end
            rv_v  = 1'b0;
            rpc_v = 32'h0;
            if (rp_k.size() > 0 && !armed && rp_k[0] == done) begin
                armed = 1'b1;
                cd    = rp_delay[0];
            end
            if (armed && cd == 0) begin
                rv_v  = 1'b1;
                rpc_v = rp_pc[0];
            end
            run_cycle(1'b1, rv_v, rpc_v, 1'b0, 14'h0, 32'h0, 1'b0);
            if (fetch_seen) begin
                done++;
            end
            if (rv_v) begin
                armed = 1'b0;
                void'(rp_k.pop_front());
                void'(rp_pc.pop_front());
                void'(rp_delay.pop_front());
            end else if (armed) begin
                cd--;
            end
            guard++;
        end
        rp_k.delete();
        rp_pc.delete();
        rp_delay.delete();
    endtask

    task automatic report_test();
        if (tests > 0) begin
            $display("Test %0d: %0d fetches, %0d misses, %0d errors %s", tests,
                     test_fetches, test_misses, test_errors,
                     (test_errors == 0) ? "ok" : "FAILED");
        end
    endtask

    initial begin
        wait (budget_cycles > 0);
        #(budget_cycles * 4 * 8);
        $display("Timeout: run did not finish within %0d cycles", budget_cycles * 4);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int          op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        longint      cycles;
        run            = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = 32'h0;
        prog_we        = 1'b0;
        prog_addr      = 14'h0;
        prog_data      = 32'h0;
        reset_req      = 1'b0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        test_errors    = 0;
        test_fetches   = 0;
        test_misses    = 0;
        pending_reset  = 1'b0;
        for (int i = 0; i < max_recs; i++) begin
            recs[i] = 32'h0;
        end
        for (int i = 0; i < 16384; i++) begin
            model_mem[i] = 32'h0;
        end
        reset_model();
        $readmemh("testbench/fetch_tests.txt", recs);

        // Cycle estimate for the watchdog
        cycles = 20;
        for (int r = 0; r < max_recs; r += 4) begin
            case (recs[r])
                1: cycles += 7;
                3: cycles += 1;
                4: cycles += 3 * longint'(recs[r+1]);
                5: cycles += longint'(recs[r+3]) + 2;
                default: cycles += 0;
            endcase
        end
        budget_cycles = cycles;

        @(posedge clk_in);
        wait_reset_done();

        for (int r = 0; r < max_recs; r += 4) begin
            op = int'(recs[r]);
            a  = recs[r+1];
            b  = recs[r+2];
            c  = recs[r+3];
            if (op == 0) begin
                break;
            end
            // Memory was rewritten, so start from a clean cache
            if (op != 1 && pending_reset) begin
                apply_reset();
                pending_reset = 1'b0;
            end
            case (op)
                1: begin
                    run_cycle(1'b0, 1'b0, 32'h0, 1'b1, a[13:0], b, 1'b0);
                    pending_reset = 1'b1;
                end
                2: begin
                    report_test();
                    tests++;
                    test_errors  = 0;
                    test_fetches = 0;
                    test_misses  = 0;
                end
                3: run_cycle(1'b1, 1'b1, a, 1'b0, 14'h0, 32'h0, 1'b0);
                4: do_fetches(int'(a));
                5: begin
                    rp_k.push_back(int'(a));
                    rp_pc.push_back(b);
                    rp_delay.push_back(int'(c));
                end
                default: begin
                    $display("Unknown record type %0d in tests file", op);
                    errors++;
                end
            endcase
        end
        report_test();
        idle_cycle();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* testbench/fetch_tests.txt */
// op a b c: 1 write (a word, b data), 2 test header (a number), 3 start pc (a pc)
// 4 fetch count (a), 5 redirect point (a fetch index, b target pc, c delay), 0 end
00000001 00000000 00100093 00000000
00000001 00000001 00200113 00000000
00000001 00000002 00300193 00000000
00000001 00000003 00400213 00000000
00000001 00000004 00500293 00000000
00000001 00000005 00600313 00000000
00000001 00000006 00700393 00000000
00000001 00000007 00800413 00000000
00000001 00000008 00900493 00000000
00000001 00000009 00a00513 00000000
00000001 0000000a 00b00593 00000000
00000001 0000000b 00c00613 00000000
00000001 0000000c 00d00693 00000000
00000001 0000000d 00e00713 00000000
00000001 0000000e 00f00793 00000000
00000001 0000000f 01000813 00000000
// Cold sequential run
00000002 00000001 00000000 00000000
00000003 00000000 00000000 00000000
00000004 00000008 00000000 00000000
// Loop over cached words
00000002 00000002 00000000 00000000
00000005 00000004 00000010 00000000
00000003 00000010 00000000 00000000
00000004 00000008 00000000 00000000
// Three tags in set 0
00000002 00000003 00000000 00000000
00000003 00000000 00000000 00000000
00000004 00000001 00000000 00000000
00000003 00000010 00000000 00000000
00000004 00000001 00000000 00000000
00000003 00000000 00000000 00000000
00000004 00000001 00000000 00000000
00000003 00000020 00000000 00000000
00000004 00000001 00000000 00000000
00000003 00000000 00000000 00000000
00000004 00000001 00000000 00000000
00000003 00000010 00000000 00000000
00000004 00000001 00000000 00000000
// Redirect during WAIT, then during WAIT2
00000002 00000004 00000000 00000000
00000005 00000001 00000024 00000001
00000003 00000030 00000000 00000000
00000004 00000003 00000000 00000000
00000005 00000000 00000014 00000002
00000003 00000038 00000000 00000000
00000004 00000002 00000000 00000000
// Rewrite memory, reset, refetch
00000002 00000005 00000000 00000000
00000001 00000000 7ff00093 00000000
00000001 00000001 7fe00113 00000000
00000001 00000002 7fd00193 00000000
00000001 00000003 7fc00213 00000000
00000003 00000000 00000000 00000000
00000004 00000004 00000000 00000000
00000000 00000000 00000000 00000000

/* verilog.f */
common/fetch_pkg.sv
icache/icache.sv
hw/imem.sv
hw/fetch_unit.sv
hw/fetch_top.sv
testbench/tb_clock.sv
testbench/fetch_tb.sv

/* Makefile */
SRCS := $(shell cat verilog.f)

.PHONY: run clean

obj_dir/Vfetch_tb: $(SRCS) verilog.f
	verilator --binary --timing -j 0 --top-module fetch_tb -f verilog.f -o Vfetch_tb

run: obj_dir/Vfetch_tb testbench/fetch_tests.txt
	./obj_dir/Vfetch_tb > sim.log
	cat sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
